// ==== verification/bcfg_cases.txt ====
# op addr data first last expected; addr, data, expected in hex, first and last 0 or 1
# rdst expects the bank bit, nop and ts take a cycle count in data, port checks pin outputs
rdst 0000 00000000 0 0 00000000
wr   0011 ffffffff 0 0 00000000
wr   0012 0000ffff 0 0 00000000
wr   0017 deadbeef 0 0 00000000
wr   0018 cafef00d 0 0 00000000
rd   0011 00000000 0 0 00000003
rd   0012 00000000 0 0 0000ffff
rd   0017 00000000 0 0 000000ef
rd   001c 00000000 0 0 bad00000
nop  0000 00000003 0 0 00000000
port 0011 00000000 0 0 00000003
port 0012 00000000 0 0 0000ffff
port 0017 00000000 0 0 000000ef
port 0018 00000000 0 0 cafef00d
pins 0000 00000000 0 0 00000000
nop  0000 00000004 0 0 00000000
rdin 0014 00000000 0 0 00000000
rdin 0015 00000000 0 0 00000000
rdin 001a 00000000 0 0 00000000
rdin 001b 00000000 0 0 00000000
rd   0100 00000000 0 0 00000000
bw   0100 11110000 1 0 00000000
rd   0101 00000000 0 0 00000000
bw   0101 22220001 0 1 00000000
rd   0101 00000000 0 0 22220001
rd   0100 00000000 0 0 11110000
rdst 0000 00000000 0 0 00000001
bw   0100 44440000 1 1 00000000
rd   0100 00000000 0 0 44440000
rd   0101 00000000 0 0 00000000
rdst 0000 00000000 0 0 00000000
ts   0001 00000005 0 0 00000000
ts   0001 00000001 0 0 00000000
rd   0018 00000000 0 0 cafef00d
rd   0300 00000000 0 0 bad00000

// ==== filelist.f ====
+incdir+hw
hw/bcfg_pkg.sv
hw/host_cmd_decoder.sv
hw/board_status.sv
hw/boot_config.sv
hw/bcfg_top.sv
verification/bcfg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the boot-config testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module bcfg_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vbcfg_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== verification/bcfg_tb.sv ====
/* boot-config subsystem testbench
   host commands from a case file, read responses checked in issue order,
   pin outputs and inputs checked against the register map */

`include "bcfg_config.svh"

module bcfg_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] SWITCH = 4'b0101;  // rotary switch setting

    logic                    sysclk;
    logic                    rst_n;
    logic [3:0]              wenid;
    logic                    cmd_valid;
    bcfg_pkg::host_cmd_t     cmd;
    logic                    resp_valid;
    bcfg_pkg::rd_resp_t      resp;
    logic [`BCFG_IO1_W-1:0]  io1_in;
    logic [`BCFG_IO1_W-1:0]  io1_out;
    logic [`BCFG_IO1_W-1:0]  io1_oe;
    logic [`BCFG_IO2_W-1:0]  io2_in;
    logic [`BCFG_IO2_W-1:0]  io2_out;
    logic [`BCFG_IO2_W-1:0]  io2_oe;
    logic                    led;

    // case table, one entry per file line
    string                   case_op[$];
    logic [`BCFG_ADDR_W-1:0] case_addr[$];
    logic [`BCFG_DATA_W-1:0] case_data[$];
    logic                    case_first[$];
    logic                    case_last[$];
    logic [`BCFG_DATA_W-1:0] case_exp[$];

    // outstanding reads, oldest first
    logic [`BCFG_DATA_W-1:0] exp_data_q[$];
    logic [`BCFG_ADDR_W-1:0] exp_addr_q[$];
    int                      exp_kind_q[$];  // 0 exact, 1 first stamp, 2 second stamp

    int                      errors = 0;
    int                      checks = 0;
    int                      cycles = 0;
    int                      limit = 0;
    int                      seed = 84;
    logic [`BCFG_DATA_W-1:0] ts_first;

    bcfg_top dut0 (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .wenid      (wenid),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .resp_valid (resp_valid),
        .resp       (resp),
        .io1_in     (io1_in),
        .io1_out    (io1_out),
        .io1_oe     (io1_oe),
        .io2_in     (io2_in),
        .io2_out    (io2_out),
        .io2_oe     (io2_oe),
        .led        (led)
    );

    initial sysclk = 1'b0;
    always #4 sysclk = ~sysclk;  // 8 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // status layout: version high, bank bit 4, board id low
    function automatic logic [31:0] status_word(input logic bank);
        status_word = {`BCFG_VERSION, 11'd0, bank, ~wenid};
    endfunction

    // pin vectors split into 32-bit register words, per bank out, oe, in
    function automatic logic [31:0] pin_word(input logic [`BCFG_ADDR_W-1:0] addr);
        logic [63:0] w;
        case (addr - `BCFG_ADDR_IO_BASE)
            16'd0, 16'd1:   w = 64'(io1_out);
            16'd2, 16'd3:   w = 64'(io1_oe);
            16'd4, 16'd5:   w = 64'(io1_in);
            16'd6, 16'd7:   w = 64'(io2_out);
            16'd8, 16'd9:   w = 64'(io2_oe);
            16'd10, 16'd11: w = 64'(io2_in);
            default:        w = '1;
        endcase
        pin_word = addr[0] ? w[63:32] : w[31:0];  // odd offsets are the high words
    endfunction

    function automatic string pin_name(input logic [`BCFG_ADDR_W-1:0] addr);
        case (addr - `BCFG_ADDR_IO_BASE)
            16'd0, 16'd1: pin_name = "io1_out";
            16'd2, 16'd3: pin_name = "io1_oe";
            16'd6, 16'd7: pin_name = "io2_out";
            16'd8, 16'd9: pin_name = "io2_oe";
            default:      pin_name = "io_pins";
        endcase
    endfunction

    task automatic load_cases(output int ok);
        int                      fd;
        int                      n;
        int                      f;
        int                      l;
        string                   line;
        string                   op;
        logic [`BCFG_ADDR_W-1:0] a;
        logic [`BCFG_DATA_W-1:0] d;
        logic [`BCFG_DATA_W-1:0] e;
        ok = 1;
        fd = $fopen("verification/bcfg_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/bcfg_cases.txt");
            ok = 0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin  // skip blanks and comments
                    n = $sscanf(line, "%s %h %h %d %d %h", op, a, d, f, l, e);
                    if (n == 6) begin
                        case_op.push_back(op);
                        case_addr.push_back(a);
                        case_data.push_back(d);
                        case_first.push_back(f[0]);
                        case_last.push_back(l[0]);
                        case_exp.push_back(e);
                    end else begin
                        $display("malformed line in case file: %s", line);
                        ok = 0;
                    end
                end
            end
            $fclose(fd);
            if (case_op.size() == 0) begin
                $display("case file holds no commands");
                ok = 0;
            end
        end
    endtask

    task automatic drive_cmd(input bcfg_pkg::host_op_e op, input logic [`BCFG_ADDR_W-1:0] addr,
                             input logic [`BCFG_DATA_W-1:0] data, input logic first,
                             input logic last);
        cmd_valid <= 1'b1;
        cmd       <= '{op: op, addr: addr, data: data, first: first, last: last};
    endtask

    task automatic expect_read(input logic [`BCFG_DATA_W-1:0] data,
                               input logic [`BCFG_ADDR_W-1:0] addr, input int kind);
        exp_data_q.push_back(data);
        exp_addr_q.push_back(addr);
        exp_kind_q.push_back(kind);
    endtask

    task automatic apply_pins();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        io1_in <= {r1[1:0], r0};
        io2_in <= {r3[7:0], r2};
    endtask

    // one case line, entered and left on a rising edge
    task automatic run_case(input int i);
        string                   op;
        logic [`BCFG_ADDR_W-1:0] addr;
        logic [`BCFG_DATA_W-1:0] data;
        logic [`BCFG_DATA_W-1:0] exp;
        op   = case_op[i];
        addr = case_addr[i];
        data = case_data[i];
        exp  = case_exp[i];
        if (op == "nop") begin
            cmd_valid <= 1'b0;
            repeat (data) @(posedge sysclk);
        end else if (op == "rd" || op == "rdst" || op == "rdin") begin
            drive_cmd(bcfg_pkg::OP_READ, addr, '0, 1'b0, 1'b0);
            if (op == "rdst")
                expect_read(status_word(exp[0]), addr, 0);  // exp column is the bank bit
            else if (op == "rdin")
                expect_read(pin_word(addr), addr, 0);
            else
                expect_read(exp, addr, 0);
            @(posedge sysclk);
        end else if (op == "wr") begin
            drive_cmd(bcfg_pkg::OP_WRITE, addr, data, 1'b0, 1'b0);
            @(posedge sysclk);
        end else if (op == "bw") begin
            drive_cmd(bcfg_pkg::OP_BLK_WRITE, addr, data, case_first[i], case_last[i]);
            @(posedge sysclk);
        end else if (op == "pins") begin
            cmd_valid <= 1'b0;
            apply_pins();
            @(posedge sysclk);
        end else if (op == "port") begin
            cmd_valid <= 1'b0;
            @(negedge sysclk);   // outputs settled
            check_value($sformatf("%s[%s]", pin_name(addr), addr[0] ? "hi" : "lo"),
                        pin_word(addr), exp);
            @(posedge sysclk);
        end else if (op == "ts") begin
            drive_cmd(bcfg_pkg::OP_READ, addr, '0, 1'b0, 1'b0);
            expect_read('0, addr, 1);
            @(posedge sysclk);
            repeat (data - 32'd1) begin
                cmd_valid <= 1'b0;
                @(posedge sysclk);
            end
            drive_cmd(bcfg_pkg::OP_READ, addr, '0, 1'b0, 1'b0);
            expect_read(data, addr, 2);  // gap in cycles
            @(posedge sysclk);
        end else begin
            errors++;
            $display("case %0d has an unknown opcode %s", i, op);
        end
    endtask

    task automatic score_response();
        logic [`BCFG_DATA_W-1:0] exp;
        logic [`BCFG_DATA_W-1:0] ts_next;
        logic [`BCFG_ADDR_W-1:0] addr;
        int                      kind;
        if (exp_data_q.size() == 0) begin
            errors++;
            $display("time %0t: read response arrived with no read outstanding", $time);
        end else begin
            exp  = exp_data_q.pop_front();
            addr = exp_addr_q.pop_front();
            kind = exp_kind_q.pop_front();
            check_value("resp.addr", {16'd0, resp.addr}, {16'd0, addr});
            if (kind == 0) begin
                check_value("resp.data", resp.data, exp);
            end else if (kind == 1) begin
                ts_first = resp.data;
            end else begin
                ts_next = resp.data + 32'd1;  // counter moved on by one since capture
                check_value("timestamp delta", resp.data - ts_first, exp);
                check_value("led", {31'd0, led}, {31'd0, ts_next[`BCFG_HEARTBEAT_BIT]});
            end
        end
    endtask

    // responses sampled mid cycle
    always @(negedge sysclk) begin
        if (rst_n && resp_valid)
            score_response();
    end

    always @(posedge sysclk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles with %0d reads unanswered",
                     cycles, exp_data_q.size());
            $display("errors: %0d, checks: %0d", errors, checks);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int ok;
        rst_n     = 1'b0;
        wenid     = SWITCH;
        cmd_valid = 1'b0;
        cmd       = '0;
        io1_in    = '0;
        io2_in    = '0;
        load_cases(ok);
        limit = 4 * case_op.size() + 200;
        if (ok == 0) begin
            $display("stimulus could not be loaded, run stopped");
            $display("sim failed");
            $finish;
        end
        repeat (3) @(posedge sysclk);
        rst_n <= 1'b1;
        for (int i = 0; i < case_op.size(); i++)
            run_case(i);
        cmd_valid <= 1'b0;
        while (exp_data_q.size() != 0)
            @(posedge sysclk);
        repeat (4) @(posedge sysclk);  // room for a stray response
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== hw/bcfg_top.sv ====
/* boot-config subsystem top
   host command decoder feeding the board status and boot-config blocks */

`include "bcfg_config.svh"

module bcfg_top (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  logic [3:0]             wenid,       // rotary switch
    input  logic                   cmd_valid,
    input  bcfg_pkg::host_cmd_t    cmd,
    output logic                   resp_valid,
    output bcfg_pkg::rd_resp_t     resp,
    input  logic [`BCFG_IO1_W-1:0] io1_in,      // connector J1
    output logic [`BCFG_IO1_W-1:0] io1_out,
    output logic [`BCFG_IO1_W-1:0] io1_oe,
    input  logic [`BCFG_IO2_W-1:0] io2_in,      // connector J2
    output logic [`BCFG_IO2_W-1:0] io2_out,
    output logic [`BCFG_IO2_W-1:0] io2_oe,
    output logic                   led
);

    bcfg_pkg::reg_bus_t      bus;
    logic                    status_hit;
    logic [`BCFG_DATA_W-1:0] status_rdata;
    logic                    cfg_hit;
    logic [`BCFG_DATA_W-1:0] cfg_rdata;
    logic                    active_bank;   // scratch bank, shown in status

    host_cmd_decoder u_dec (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .bus          (bus),
        .status_hit   (status_hit),
        .status_rdata (status_rdata),
        .cfg_hit      (cfg_hit),
        .cfg_rdata    (cfg_rdata),
        .resp_valid   (resp_valid),
        .resp         (resp)
    );

    board_status u_status (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .wenid       (wenid),
        .active_bank (active_bank),
        .bus         (bus),
        .hit         (status_hit),
        .rdata       (status_rdata),
        .led         (led)
    );

    boot_config u_bcfg (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .bus         (bus),
        .io1_in      (io1_in),
        .io2_in      (io2_in),
        .io1_out     (io1_out),
        .io1_oe      (io1_oe),
        .io2_out     (io2_out),
        .io2_oe      (io2_oe),
        .active_bank (active_bank),
        .hit         (cfg_hit),
        .rdata       (cfg_rdata)
    );

endmodule

// ==== hw/boot_config.sv ====
/* boot configuration block
   connector bank out/oe registers, synchronized pin inputs and a
   double-banked scratch table swapped by the block commit */

`include "bcfg_config.svh"

module boot_config (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  bcfg_pkg::reg_bus_t      bus,
    input  logic [`BCFG_IO1_W-1:0]  io1_in,
    input  logic [`BCFG_IO2_W-1:0]  io2_in,
    output logic [`BCFG_IO1_W-1:0]  io1_out,
    output logic [`BCFG_IO1_W-1:0]  io1_oe,
    output logic [`BCFG_IO2_W-1:0]  io2_out,
    output logic [`BCFG_IO2_W-1:0]  io2_oe,
    output logic                    active_bank,
    output logic                    hit,
    output logic [`BCFG_DATA_W-1:0] rdata
);

    localparam int IDX_W = $clog2(`BCFG_BANK_DEPTH);
    localparam int SLOTS = 2 * `BCFG_BANK_DEPTH;
    localparam logic [`BCFG_ADDR_W-1:0] IO_BASE  = `BCFG_ADDR_IO_BASE;
    localparam logic [`BCFG_ADDR_W-1:0] SCR_BASE = `BCFG_ADDR_SCRATCH;

    // pin input synchronizers
    logic [`BCFG_IO1_W-1:0] io1_meta;
    logic [`BCFG_IO1_W-1:0] io1_sync;
    logic [`BCFG_IO2_W-1:0] io2_meta;
    logic [`BCFG_IO2_W-1:0] io2_sync;

    // scratch table, bank is the top index bit
    logic [`BCFG_DATA_W-1:0] scratch [SLOTS];
    logic [SLOTS-1:0]        scr_vld;   // unwritten slots read as zero

    logic             next_bank;  // active bank once this cycle's commit lands
    logic             io_we;
    logic             scr_we;
    logic             wr_bank;
    logic [IDX_W:0]   wr_slot;
    logic [IDX_W:0]   rd_slot;
    logic [3:0]       wr_off;
    logic [3:0]       rd_off;

    // zero-extended views, upper halves read unimplemented bits as 0
    logic [63:0] o1_x;
    logic [63:0] e1_x;
    logic [63:0] i1_x;
    logic [63:0] o2_x;
    logic [63:0] e2_x;
    logic [63:0] i2_x;

    logic [`BCFG_DATA_W-1:0] rd_word;
    logic                    rd_map;

    assign next_bank = active_bank ^ bus.blk_wen;
    assign wr_bank   = ~next_bank;   // writes always go to the hidden bank

    assign wr_off = bus.waddr[3:0];
    assign rd_off = bus.raddr[3:0];

    assign io_we  = bus.wen && (bus.waddr[15:4] == IO_BASE[15:4]) && (wr_off < 4'd12);
    assign scr_we = bus.wen && (bus.waddr[15:IDX_W] == SCR_BASE[15:IDX_W]);

    assign wr_slot = {wr_bank, bus.waddr[IDX_W-1:0]};
    assign rd_slot = {next_bank, bus.raddr[IDX_W-1:0]};

    // two-flop sync, no reset needed on data path
    always_ff @(posedge sysclk) begin
        io1_meta <= io1_in;
        io1_sync <= io1_meta;
        io2_meta <= io2_in;
        io2_sync <= io2_meta;
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            io1_out     <= '0;
            io1_oe      <= '0;   // all pins tristated
            io2_out     <= '0;
            io2_oe      <= '0;
            active_bank <= 1'b0;
            scr_vld     <= '0;
        end else begin
            if (bus.blk_wen)
                active_bank <= ~active_bank;  // swap banks on commit
            if (io_we) begin
                case (wr_off)
                    4'd0:  io1_out[31:0] <= bus.wdata;
                    4'd1:  io1_out[`BCFG_IO1_W-1:32] <= bus.wdata[`BCFG_IO1_W-33:0];
                    4'd2:  io1_oe[31:0] <= bus.wdata;
                    4'd3:  io1_oe[`BCFG_IO1_W-1:32] <= bus.wdata[`BCFG_IO1_W-33:0];
                    4'd6:  io2_out[31:0] <= bus.wdata;
                    4'd7:  io2_out[`BCFG_IO2_W-1:32] <= bus.wdata[`BCFG_IO2_W-33:0];
                    4'd8:  io2_oe[31:0] <= bus.wdata;
                    4'd9:  io2_oe[`BCFG_IO2_W-1:32] <= bus.wdata[`BCFG_IO2_W-33:0];
                    default: ;   // in_lo/in_hi are read only
                endcase
            end
            if (scr_we)
                scr_vld[wr_slot] <= 1'b1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (scr_we)
            scratch[wr_slot] <= bus.wdata;
    end

    assign o1_x = 64'(io1_out);
    assign e1_x = 64'(io1_oe);
    assign i1_x = 64'(io1_sync);
    assign o2_x = 64'(io2_out);
    assign e2_x = 64'(io2_oe);
    assign i2_x = 64'(io2_sync);

    always_comb begin
        rd_map  = 1'b0;
        rd_word = '0;
        if (bus.raddr[15:4] == IO_BASE[15:4] && rd_off < 4'd12) begin
            rd_map = 1'b1;
            case (rd_off)
                4'd0:    rd_word = o1_x[31:0];
                4'd1:    rd_word = o1_x[63:32];
                4'd2:    rd_word = e1_x[31:0];
                4'd3:    rd_word = e1_x[63:32];
                4'd4:    rd_word = i1_x[31:0];
                4'd5:    rd_word = i1_x[63:32];
                4'd6:    rd_word = o2_x[31:0];
                4'd7:    rd_word = o2_x[63:32];
                4'd8:    rd_word = e2_x[31:0];
                4'd9:    rd_word = e2_x[63:32];
                4'd10:   rd_word = i2_x[31:0];
                default: rd_word = i2_x[63:32];
            endcase
        end else if (bus.raddr[15:IDX_W] == SCR_BASE[15:IDX_W]) begin
            rd_map  = 1'b1;
            rd_word = scr_vld[rd_slot] ? scratch[rd_slot] : '0;  // visible bank
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            hit <= 1'b0;
        else
            hit <= bus.ren && rd_map;
    end

    always_ff @(posedge sysclk) begin
        if (bus.ren)
            rdata <= rd_word;
    end

    // bank changes on every commit and at no other time
    a_bank_toggle: assert property (@(posedge sysclk) disable iff (!rst_n)
        1'b1 |=> ((active_bank != $past(active_bank)) == $past(bus.blk_wen)));

    // written bank is still hidden once the write has landed
    a_write_hidden: assert property (@(posedge sysclk) disable iff (!rst_n)
        scr_we |=> (active_bank != $past(wr_bank)));

endmodule

// ==== hw/board_status.sv ====
/* board status registers
   board id from the rotary switch, firmware version, free-running
   timestamp and heartbeat LED, readable over the register bus */

`include "bcfg_config.svh"

module board_status (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic [3:0]              wenid,
    input  logic                    active_bank,
    input  bcfg_pkg::reg_bus_t      bus,
    output logic                    hit,
    output logic [`BCFG_DATA_W-1:0] rdata,
    output logic                    led
);

    logic [3:0]              board_id;
    logic [`BCFG_DATA_W-1:0] timestamp;   // sysclk cycles since reset
    logic                    bank_now;    // bank after a commit on this cycle
    logic [`BCFG_DATA_W-1:0] status_word;
    logic [`BCFG_DATA_W-1:0] rd_word;
    logic                    rd_map;

    assign board_id = ~wenid;  // switch is active low

    // pending commit already counts, matches scratch read path
    assign bank_now = active_bank ^ bus.blk_wen;

    assign status_word = {`BCFG_VERSION, 11'd0, bank_now, board_id};

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    assign led = timestamp[`BCFG_HEARTBEAT_BIT];  // blinks

    always_comb begin
        rd_map  = 1'b1;
        rd_word = '0;
        case (bus.raddr)
            `BCFG_ADDR_STATUS:    rd_word = status_word;
            `BCFG_ADDR_TIMESTAMP: rd_word = timestamp + 1'b1;  // value after this edge
            default:              rd_map  = 1'b0;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            hit <= 1'b0;
        else
            hit <= bus.ren && rd_map;
    end

    always_ff @(posedge sysclk) begin
        if (bus.ren)
            rdata <= rd_word;
    end

    // answer only one cycle after a read
    a_hit_after_ren: assert property (@(posedge sysclk) disable iff (!rst_n)
        hit |-> $past(bus.ren));

endmodule

// ==== hw/host_cmd_decoder.sv ====
/* host command decoder
   turns host command strobes into register bus cycles,
   merges the block answers and returns read responses */

`include "bcfg_config.svh"

module host_cmd_decoder (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic                    cmd_valid,
    input  bcfg_pkg::host_cmd_t     cmd,
    output bcfg_pkg::reg_bus_t      bus,
    input  logic                    status_hit,
    input  logic [`BCFG_DATA_W-1:0] status_rdata,
    input  logic                    cfg_hit,
    input  logic [`BCFG_DATA_W-1:0] cfg_rdata,
    output logic                    resp_valid,
    output bcfg_pkg::rd_resp_t      resp
);

    logic is_rd;
    logic is_blk;
    logic is_wr;

    // bus strobes
    logic ren_q;
    logic wen_q;
    logic blk_wstart_q;
    logic blk_wen_q;
    logic blk_last_q;   // last block word now on the bus
    logic blk_open;     // between first and last block word

    // bus payload
    logic [`BCFG_ADDR_W-1:0] raddr_q;
    logic [`BCFG_ADDR_W-1:0] waddr_q;
    logic [`BCFG_DATA_W-1:0] wdata_q;

    // read return pipe
    logic                    rd_pend;      // blocks answering this cycle
    logic [`BCFG_ADDR_W-1:0] rd_addr_q;    // address paired with that answer
    logic [`BCFG_DATA_W-1:0] rd_merge;
    logic [`BCFG_DATA_W-1:0] resp_data_q;
    logic [`BCFG_ADDR_W-1:0] resp_addr_q;

    assign is_rd  = cmd_valid && (cmd.op == bcfg_pkg::OP_READ);
    assign is_blk = cmd_valid && (cmd.op == bcfg_pkg::OP_BLK_WRITE);
    assign is_wr  = (cmd_valid && (cmd.op == bcfg_pkg::OP_WRITE)) || is_blk;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            ren_q        <= 1'b0;
            wen_q        <= 1'b0;
            blk_wstart_q <= 1'b0;
            blk_wen_q    <= 1'b0;
            blk_last_q   <= 1'b0;
            blk_open     <= 1'b0;
            rd_pend      <= 1'b0;
            resp_valid   <= 1'b0;
        end else begin
            ren_q        <= is_rd;
            wen_q        <= is_wr;
            blk_wstart_q <= is_blk && cmd.first;
            blk_last_q   <= is_blk && cmd.last;
            blk_wen_q    <= blk_last_q;      // commit one cycle after last wen
            if (is_blk)
                blk_open <= !cmd.last;      // single-word block never opens
            rd_pend      <= ren_q;
            resp_valid   <= rd_pend;
        end
    end

    // payload only moves with its strobe
    always_ff @(posedge sysclk) begin
        if (is_rd)
            raddr_q <= cmd.addr;
        if (is_wr) begin
            waddr_q <= cmd.addr;
            wdata_q <= cmd.data;
        end
        if (ren_q)
            rd_addr_q <= raddr_q;
        if (rd_pend) begin
            resp_data_q <= rd_merge;
            resp_addr_q <= rd_addr_q;
        end
    end

    // at most one block claims an address
    always_comb begin
        if (status_hit)
            rd_merge = status_rdata;
        else if (cfg_hit)
            rd_merge = cfg_rdata;
        else
            rd_merge = `BCFG_UNMAPPED;  // nobody home
    end

    assign bus = '{raddr: raddr_q, waddr: waddr_q, wdata: wdata_q, wen: wen_q,
                   blk_wstart: blk_wstart_q, blk_wen: blk_wen_q, ren: ren_q};

    assign resp = '{data: resp_data_q, addr: resp_addr_q};

    // one command per cycle, so never both strobes
    a_wen_ren_excl: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(wen_q && ren_q));

    // commit only right after the last block word
    a_commit_after_blk: assert property (@(posedge sysclk) disable iff (!rst_n)
        blk_wen_q |-> $past(wen_q && blk_last_q));

    // new block may not start inside an open one
    a_no_nested_blk: assert property (@(posedge sysclk) disable iff (!rst_n)
        (is_blk && cmd.first) |-> !blk_open);

endmodule

// ==== hw/bcfg_pkg.sv ====
/* boot-config shared types
   host command, register bus and read response */

`include "bcfg_config.svh"

package bcfg_pkg;

    // host opcodes
    typedef enum logic [1:0] {
        OP_NOP       = 2'd0,
        OP_READ      = 2'd1,
        OP_WRITE     = 2'd2,
        OP_BLK_WRITE = 2'd3  // one word of a block write
    } host_op_e;

    // one command word from the host link
    typedef struct packed {
        host_op_e                op;
        logic [`BCFG_ADDR_W-1:0] addr;
        logic [`BCFG_DATA_W-1:0] data;
        logic                    first;  // block start
        logic                    last;   // block end
    } host_cmd_t;

    // board register bus, decoder to blocks
    typedef struct packed {
        logic [`BCFG_ADDR_W-1:0] raddr;
        logic [`BCFG_ADDR_W-1:0] waddr;
        logic [`BCFG_DATA_W-1:0] wdata;
        logic                    wen;         // single or block word write
        logic                    blk_wstart;  // first word of a block
        logic                    blk_wen;     // block commit, after last word
        logic                    ren;         // read strobe
    } reg_bus_t;

    // read answer back to the host
    typedef struct packed {
        logic [`BCFG_DATA_W-1:0] data;
        logic [`BCFG_ADDR_W-1:0] addr;
    } rd_resp_t;

    // status word layout
    //   [3:0]   board id
    //   [4]     active scratch bank
    //   [15:5]  zero
    //   [31:16] firmware version

endpackage

// ==== hw/bcfg_config.svh ====
/* boot-config subsystem constants
   bus widths, connector bank sizes, register map and board identity */

`ifndef BCFG_CONFIG_SVH
`define BCFG_CONFIG_SVH

// bus widths
`define BCFG_ADDR_W         16
`define BCFG_DATA_W         32

// connector banks, pin counts
`define BCFG_IO1_W          34
`define BCFG_IO2_W          40

// words per scratch bank, two banks total
`define BCFG_BANK_DEPTH     16

// firmware version, lands in status[31:16]
`define BCFG_VERSION        16'h3102

// timestamp bit shown on the heartbeat LED
`define BCFG_HEARTBEAT_BIT  6

// register map
`define BCFG_ADDR_STATUS    16'h0000
`define BCFG_ADDR_TIMESTAMP 16'h0001
`define BCFG_ADDR_IO_BASE   16'h0010  // 12 words, bank 1 then bank 2
`define BCFG_ADDR_SCRATCH   16'h0100  // scratch table, one bank visible

// read value for addresses nobody claims
`define BCFG_UNMAPPED       32'hBAD0_0000

`endif
